/* source/cnn_layer_pkg.sv */
//----------------------------------------------------------
// CNN layer description types
// layer kinds and the packed configuration of one layer,
// feature maps laid out as [channel][row][column]
//----------------------------------------------------------
package cnn_layer_pkg;

    // only PW and DW have behaviour, STD and LIN run as PW
    typedef enum logic [1:0] {
        LT_PW  = 2'd0,
        LT_DW  = 2'd1,
        LT_STD = 2'd2,
        LT_LIN = 2'd3
    } layer_type_e;

    //------------------------------------------------------
    // layer configuration, one field per register
    //------------------------------------------------------
    typedef struct packed {
        layer_type_e  layer_type;
        logic [6:0]   in_r;         // rows, same for ofmap
        logic [9:0]   in_c;         // columns, same for ofmap
        logic [9:0]   in_d;         // input channels
        logic [9:0]   out_k;        // output channels
        logic [6:0]   tile_d;       // input channels per tile
        logic [6:0]   tile_k;       // output channels per tile
        logic [15:0]  tile_n;       // pixels per ifmap xfer, rows for DW
        logic [7:0]   num_n;        // spatial tiles per layer
        logic [31:0]  base_ifmap;
        logic [31:0]  base_weight;
        logic [31:0]  base_bias;
        logic [31:0]  base_ofmap;   // opsum region
    } layer_cfg_t;

endpackage

/* source/dma_cmd_pkg.sv */
//----------------------------------------------------------
// DMA command types
// transfer kinds and the request handed to the DMA engine
//----------------------------------------------------------
package dma_cmd_pkg;

    parameter int ADDR_W = 32;   // address and length width

    // encoding follows the DMA engine's input_type field
    typedef enum logic [2:0] {
        XK_FILTER = 3'd0,
        XK_IFMAP  = 3'd1,
        XK_BIAS   = 3'd2,
        XK_OPSUM  = 3'd3
    } xfer_kind_e;

    //------------------------------------------------------
    // one request, valid for the cycle of req_valid
    //------------------------------------------------------
    typedef struct packed {
        xfer_kind_e          kind;
        logic [ADDR_W-1:0]   addr;   // byte address
        logic [ADDR_W-1:0]   len;    // byte count
    } dma_req_t;

endpackage

/* source/layer_cfg_regs.sv */
//----------------------------------------------------------
// Layer configuration registers
// write-only register file for one layer description,
// a write of 1 to register 15 gives the start pulse
//----------------------------------------------------------
module layer_cfg_regs #(
    parameter int CFG_ADDR_W = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_we_i,
    input  logic [CFG_ADDR_W-1:0]      cfg_addr_i,
    input  logic [31:0]                cfg_wdata_i,
    output cnn_layer_pkg::layer_cfg_t  cfg_o,
    output logic                       start_o
);

    logic go_wr;

    assign go_wr = cfg_we_i && (cfg_addr_i == CFG_ADDR_W'(15)) && (cfg_wdata_i == 32'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_o   <= '0;
            start_o <= 1'b0;
        end else begin
            start_o <= go_wr;   // single cycle
            if (cfg_we_i) begin
                case (cfg_addr_i)
                    CFG_ADDR_W'(0):
                        cfg_o.layer_type <= cnn_layer_pkg::layer_type_e'(cfg_wdata_i[1:0]);
                    CFG_ADDR_W'(1):  cfg_o.in_r        <= cfg_wdata_i[6:0];
                    CFG_ADDR_W'(2):  cfg_o.in_c        <= cfg_wdata_i[9:0];
                    CFG_ADDR_W'(3):  cfg_o.in_d        <= cfg_wdata_i[9:0];
                    CFG_ADDR_W'(4):  cfg_o.out_k       <= cfg_wdata_i[9:0];
                    CFG_ADDR_W'(5):  cfg_o.tile_d      <= cfg_wdata_i[6:0];
                    CFG_ADDR_W'(6):  cfg_o.tile_k      <= cfg_wdata_i[6:0];
                    CFG_ADDR_W'(7):  cfg_o.tile_n      <= cfg_wdata_i[15:0];
                    CFG_ADDR_W'(8):  cfg_o.num_n       <= cfg_wdata_i[7:0];
                    CFG_ADDR_W'(9):  cfg_o.base_ifmap  <= cfg_wdata_i;
                    CFG_ADDR_W'(10): cfg_o.base_weight <= cfg_wdata_i;
                    CFG_ADDR_W'(11): cfg_o.base_bias   <= cfg_wdata_i;
                    CFG_ADDR_W'(12): cfg_o.base_ofmap  <= cfg_wdata_i;
                    default: ;   // 13..15 hold nothing
                endcase
            end
        end
    end

endmodule

/* source/tile_scheduler.sv */
//----------------------------------------------------------
// Tile scheduler
// walks n, k and d tiles of one layer and hands each
// transfer kind to the address generator
//----------------------------------------------------------
module tile_scheduler (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cnn_layer_pkg::layer_cfg_t  cfg_i,
    input  logic                       start_i,
    input  logic                       xfer_done_i,
    output logic                       issue_o,
    output dma_cmd_pkg::xfer_kind_e    kind_o,
    output logic [7:0]                 n_idx_o,
    output logic [6:0]                 k_idx_o,
    output logic [6:0]                 d_idx_o,
    output logic                       layer_done_o
);

    typedef enum logic [2:0] {
        IDLE, BIAS, FILTER, IFMAP, OPSUM, NEXT, DONE
    } state_e;

    state_e      state, last_q, nxt_state;
    logic [7:0]  n_q, n_nxt;
    logic [6:0]  k_q, k_nxt, d_q, d_nxt;
    logic [10:0] k_sum, d_sum;
    logic [9:0]  k_tiles, d_tiles;
    logic        k_last, d_last, layer_last;

    //------------------------------------------------------
    // tile counts, rounded up
    //------------------------------------------------------
    assign k_sum   = {1'b0, cfg_i.out_k} + {4'b0, cfg_i.tile_k} - 11'd1;
    assign d_sum   = {1'b0, cfg_i.in_d} + {4'b0, cfg_i.tile_d} - 11'd1;
    assign k_tiles = 10'(k_sum / {4'b0, cfg_i.tile_k});
    assign d_tiles = (cfg_i.layer_type == cnn_layer_pkg::LT_DW) ? 10'd1
                                                                : 10'(d_sum / {4'b0, cfg_i.tile_d});

    assign k_last     = ({3'b0, k_q} == k_tiles - 10'd1);
    assign d_last     = ({3'b0, d_q} == d_tiles - 10'd1);
    assign layer_last = k_last && (n_q == cfg_i.num_n - 8'd1);

    //------------------------------------------------------
    // step logic, only active in NEXT
    //------------------------------------------------------
    always_comb begin
        nxt_state = state;
        n_nxt     = n_q;
        k_nxt     = k_q;
        d_nxt     = d_q;
        if (state == NEXT) begin
            case (last_q)
                BIAS:   nxt_state = FILTER;
                FILTER: nxt_state = IFMAP;
                IFMAP: begin
                    if (d_last) begin
                        nxt_state = OPSUM;   // write back the k group
                    end else begin
                        d_nxt     = d_q + 7'd1;
                        nxt_state = FILTER;  // no bias past d=0
                    end
                end
                OPSUM: begin
                    d_nxt     = '0;
                    nxt_state = BIAS;
                    if (k_last) begin
                        k_nxt = '0;
                        n_nxt = n_q + 8'd1;
                    end else begin
                        k_nxt = k_q + 7'd1;
                    end
                end
                default: nxt_state = BIAS;   // first step of the layer
            endcase
        end
    end

    always_comb begin
        case (nxt_state)
            BIAS:    kind_o = dma_cmd_pkg::XK_BIAS;
            IFMAP:   kind_o = dma_cmd_pkg::XK_IFMAP;
            OPSUM:   kind_o = dma_cmd_pkg::XK_OPSUM;
            default: kind_o = dma_cmd_pkg::XK_FILTER;
        endcase
    end

    assign issue_o      = (state == NEXT);
    assign n_idx_o      = n_nxt;
    assign k_idx_o      = k_nxt;
    assign d_idx_o      = d_nxt;
    assign layer_done_o = (state == DONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            last_q <= IDLE;
            n_q    <= '0;
            k_q    <= '0;
            d_q    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        n_q    <= '0;
                        k_q    <= '0;
                        d_q    <= '0;
                        last_q <= IDLE;
                        state  <= NEXT;
                    end
                end
                NEXT: begin
                    state <= nxt_state;
                    n_q   <= n_nxt;
                    k_q   <= k_nxt;
                    d_q   <= d_nxt;
                end
                BIAS, FILTER, IFMAP: begin
                    if (xfer_done_i) begin
                        last_q <= state;
                        state  <= NEXT;
                    end
                end
                OPSUM: begin
                    if (xfer_done_i) begin
                        last_q <= OPSUM;
                        state  <= layer_last ? DONE : NEXT;
                    end
                end
                default: state <= IDLE;   // DONE lasts one cycle
            endcase
        end
    end

endmodule

/* source/dma_addr_gen.sv */
//----------------------------------------------------------
// DMA address generator
// turns each scheduler step into byte address and length,
// repeats ifmap and opsum requests once per channel
//----------------------------------------------------------
module dma_addr_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cnn_layer_pkg::layer_cfg_t  cfg_i,
    input  logic                       issue_i,
    input  dma_cmd_pkg::xfer_kind_e    kind_i,
    input  logic [7:0]                 n_idx_i,
    input  logic [6:0]                 k_idx_i,
    input  logic [6:0]                 d_idx_i,
    input  logic                       dma_done_i,
    output logic                       req_valid_o,
    output dma_cmd_pkg::dma_req_t      dma_req_o,
    output logic                       tile_xfer_done_o
);

    typedef logic [dma_cmd_pkg::ADDR_W-1:0] word_t;

    dma_cmd_pkg::xfer_kind_e kind_q, cur_kind;
    dma_cmd_pkg::dma_req_t   req_d;
    logic [6:0]              ch_q, ch_sel, grp_size;
    logic                    is_dw, grp_kind, grp_last, reissue;
    word_t                   plane, k_off, chan_k, chan_d, chan_if, xlen, spat;

    assign is_dw    = (cfg_i.layer_type == cnn_layer_pkg::LT_DW);
    assign cur_kind = issue_i ? kind_i : kind_q;
    assign ch_sel   = issue_i ? 7'd0 : ch_q + 7'd1;   // channel of the next request

    //------------------------------------------------------
    // channel group bookkeeping
    //------------------------------------------------------
    assign grp_kind = (kind_q == dma_cmd_pkg::XK_IFMAP) || (kind_q == dma_cmd_pkg::XK_OPSUM);
    assign grp_size = (kind_q == dma_cmd_pkg::XK_IFMAP && !is_dw) ? cfg_i.tile_d
                                                                   : cfg_i.tile_k;
    assign grp_last = (ch_q == grp_size - 7'd1);
    assign reissue  = dma_done_i && grp_kind && !grp_last;

    //------------------------------------------------------
    // offset terms
    //------------------------------------------------------
    assign plane   = word_t'(cfg_i.in_r) * word_t'(cfg_i.in_c);
    assign k_off   = word_t'(k_idx_i) * word_t'(cfg_i.tile_k);
    assign chan_k  = word_t'(ch_sel) + k_off;
    assign chan_d  = word_t'(ch_sel) + word_t'(d_idx_i) * word_t'(cfg_i.tile_d);
    assign chan_if = is_dw ? chan_k : chan_d;   // DW reads its own k channels
    assign xlen    = is_dw ? word_t'(cfg_i.tile_n) * word_t'(cfg_i.in_c)
                           : word_t'(cfg_i.tile_n);   // DW tile_n counts rows
    assign spat    = word_t'(n_idx_i) * xlen;

    always_comb begin
        req_d.kind = cur_kind;
        case (cur_kind)
            dma_cmd_pkg::XK_FILTER: begin
                if (is_dw) begin
                    req_d.addr = cfg_i.base_weight + k_off * word_t'(9);   // 3x3 per channel
                    req_d.len  = word_t'(cfg_i.tile_k) * word_t'(9);
                end else begin
                    req_d.addr = cfg_i.base_weight + k_off * word_t'(cfg_i.tile_d)
                               + word_t'(d_idx_i) * word_t'(cfg_i.tile_d)
                                 * word_t'(cfg_i.out_k);
                    req_d.len  = word_t'(cfg_i.tile_d) * word_t'(cfg_i.tile_k);
                end
            end
            dma_cmd_pkg::XK_BIAS: begin
                req_d.addr = cfg_i.base_bias + (k_off << 1);   // 2-byte bias
                req_d.len  = word_t'(cfg_i.tile_k) << 1;
            end
            dma_cmd_pkg::XK_IFMAP: begin
                req_d.addr = cfg_i.base_ifmap + chan_if * plane + spat;
                req_d.len  = xlen;
            end
            dma_cmd_pkg::XK_OPSUM: begin
                req_d.addr = cfg_i.base_ofmap + ((chan_k * plane + spat) << 1);   // 2-byte psum
                req_d.len  = xlen << 1;
            end
            default: begin
                req_d.addr = '0;
                req_d.len  = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kind_q           <= dma_cmd_pkg::XK_FILTER;
            ch_q             <= '0;
            req_valid_o      <= 1'b0;
            tile_xfer_done_o <= 1'b0;
        end else begin
            req_valid_o      <= issue_i || reissue;
            tile_xfer_done_o <= dma_done_i && !reissue;   // last channel or single xfer
            if (issue_i) begin
                kind_q <= kind_i;
                ch_q   <= '0;
            end else if (reissue) begin
                ch_q <= ch_sel;
            end else if (dma_done_i) begin
                ch_q <= '0;
            end
        end
    end

    // request payload, loaded with each valid
    always_ff @(posedge clk) begin
        if (issue_i || reissue) begin
            dma_req_o <= req_d;
        end
    end

endmodule

/* source/dma_ctrl_top.sv */
//----------------------------------------------------------
// DMA command controller
// configuration registers, tile scheduler and address
// generator for PW and DW layers
//----------------------------------------------------------
module dma_ctrl_top #(
    parameter int CFG_ADDR_W = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cfg_we_i,
    input  logic [CFG_ADDR_W-1:0]  cfg_addr_i,
    input  logic [31:0]            cfg_wdata_i,
    input  logic                   dma_done_i,
    output logic                   req_valid_o,
    output dma_cmd_pkg::dma_req_t  dma_req_o,
    output logic                   layer_done_o
);

    cnn_layer_pkg::layer_cfg_t cfg;
    dma_cmd_pkg::xfer_kind_e   kind;
    logic                      start, issue, tile_xfer_done;
    logic [7:0]                n_idx;
    logic [6:0]                k_idx, d_idx;

    layer_cfg_regs #(
        .CFG_ADDR_W (CFG_ADDR_W)
    ) i_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_o       (cfg),
        .start_o     (start)
    );

    tile_scheduler i_sched (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_i        (cfg),
        .start_i      (start),
        .xfer_done_i  (tile_xfer_done),
        .issue_o      (issue),
        .kind_o       (kind),
        .n_idx_o      (n_idx),
        .k_idx_o      (k_idx),
        .d_idx_o      (d_idx),
        .layer_done_o (layer_done_o)
    );

    dma_addr_gen i_addr_gen (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg_i            (cfg),
        .issue_i          (issue),
        .kind_i           (kind),
        .n_idx_i          (n_idx),
        .k_idx_i          (k_idx),
        .d_idx_i          (d_idx),
        .dma_done_i       (dma_done_i),
        .req_valid_o      (req_valid_o),
        .dma_req_o        (dma_req_o),
        .tile_xfer_done_o (tile_xfer_done)
    );

endmodule

/* dv/dma_ctrl_tb.sv */
//----------------------------------------------------------
// DMA controller testbench
// programs layers from the trace file, plays the DMA engine
// with random delays and checks every request
//----------------------------------------------------------
module dma_ctrl_tb;

    localparam int CFG_ADDR_W = 4;

    logic                  clk = 1'b0;
    logic                  rst_n, cfg_we_i, dma_done_i;
    logic [CFG_ADDR_W-1:0] cfg_addr_i;
    logic [31:0]           cfg_wdata_i;
    logic                  req_valid_o, layer_done_o;
    dma_cmd_pkg::dma_req_t dma_req_o;

    logic [31:0] cfg_addr_q[$], cfg_data_q[$];
    logic [31:0] exp_kind_q[$], exp_addr_q[$], exp_len_q[$];
    int          layer_ncfg_q[$], layer_nreq_q[$];
    int          cfg_pos = 0, req_pos = 0, total_exp = 0, wd_cycles = 0;
    int          mism_cnt = 0, fail_cnt = 0, proto_cnt = 0, seen_reqs = 0, done_cnt = 0;
    logic        layer_open = 1'b0, last_done_given = 1'b0, outstanding = 1'b0;
    logic [31:0] lfsr = 32'hcd58_d2d1;

    dma_ctrl_top #(
        .CFG_ADDR_W (CFG_ADDR_W)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .dma_done_i   (dma_done_i),
        .req_valid_o  (req_valid_o),
        .dma_req_o    (dma_req_o),
        .layer_done_o (layer_done_o)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois form with right shift
    endfunction

    task automatic next_delay(output int cycles);
        logic [2:0] bits;
        bits = '0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[1:0], lfsr[0]};
        end
        cycles = int'(bits) + 1;   // 1..8
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mism_cnt++;
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr[CFG_ADDR_W-1:0];
        cfg_wdata_i = data;
        @(negedge clk);
        cfg_we_i    = 1'b0;
    endtask

    //------------------------------------------------------
    // trace parser reads the whole file before the run
    //------------------------------------------------------
    task automatic load_trace();
        int          fd, code, nc, nr;
        logic        go_seen;
        string       tok, line;
        logic [31:0] a, d, l;
        fd = $fopen("dv/dma_ctrl_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file dv/dma_ctrl_trace.txt");
            fail_cnt++;
            return;
        end
        nc      = 0;
        nr      = 0;
        go_seen = 1'b0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(line, fd);   // comment to end of line
            end else if (tok == "cfg") begin
                code = $fscanf(fd, "%h %h", a, d);
                if (code != 2) begin
                    $display("trace file has a cfg entry without register and data");
                    fail_cnt++;
                end
                cfg_addr_q.push_back(a);
                cfg_data_q.push_back(d);
                nc++;
            end else if (tok == "go") begin
                go_seen = 1'b1;
            end else if (tok == "req") begin
                code = $fscanf(fd, "%h %h %h", d, a, l);
                if (code != 3) begin
                    $display("trace file has a req entry without kind, address and length");
                    fail_cnt++;
                end
                exp_kind_q.push_back(d);
                exp_addr_q.push_back(a);
                exp_len_q.push_back(l);
                nr++;
            end else if (tok == "end") begin
                if (!go_seen) begin
                    $display("trace layer %0d has no go", layer_nreq_q.size());
                    fail_cnt++;
                end
                layer_ncfg_q.push_back(nc);
                layer_nreq_q.push_back(nr);
                total_exp += nr;
                nc      = 0;
                nr      = 0;
                go_seen = 1'b0;
            end else begin
                $display("unknown word '%s' in trace file", tok);
                fail_cnt++;
            end
        end
        $fclose(fd);
    endtask

    // programs one layer and answers its requests in order
    task automatic run_layer(input int nc, input int nr);
        int dly;
        for (int i = 0; i < nc; i++) begin
            write_reg(cfg_addr_q[cfg_pos], cfg_data_q[cfg_pos]);
            cfg_pos++;
        end
        layer_open = 1'b1;
        write_reg(32'd15, 32'd1);
        for (int i = 0; i < nr; i++) begin
            while (!req_valid_o) @(negedge clk);
            check_val("dma_req_o.kind", 32'(dma_req_o.kind), exp_kind_q[req_pos]);
            check_val("dma_req_o.addr", dma_req_o.addr, exp_addr_q[req_pos]);
            check_val("dma_req_o.len", dma_req_o.len, exp_len_q[req_pos]);
            req_pos++;
            if (i == 2) write_reg(32'd15, 32'd1);   // go while busy
            next_delay(dly);
            repeat (dly) @(negedge clk);
            if (i == nr - 1) last_done_given = 1'b1;
            dma_done_i = 1'b1;
            @(negedge clk);
            dma_done_i = 1'b0;
        end
        while (!layer_done_o) @(negedge clk);
        @(negedge clk);   // let the monitor see the pulse
        layer_open      = 1'b0;
        last_done_given = 1'b0;
    endtask

    //------------------------------------------------------
    // protocol monitor sampled at the rising edge
    //------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (dma_done_i) outstanding = 1'b0;
            if (req_valid_o) begin
                seen_reqs++;
                if (!layer_open) begin
                    $display("request at %0t while no layer was started", $time);
                    proto_cnt++;
                end
                if (outstanding) begin
                    $display("request at %0t before the done of the previous one", $time);
                    proto_cnt++;
                end
                outstanding = 1'b1;
            end
            if (layer_done_o) begin
                done_cnt++;
                if (!last_done_given) begin
                    $display("layer_done_o at %0t before the last opsum was done", $time);
                    proto_cnt++;
                end
            end
        end
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
                 wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        dma_done_i  = 1'b0;
        load_trace();
        wd_cycles = 200 * (total_exp + 10 * layer_nreq_q.size());
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);   // idle after reset
        foreach (layer_nreq_q[i]) begin
            run_layer(layer_ncfg_q[i], layer_nreq_q[i]);
        end
        repeat (20) @(negedge clk);   // no stray requests or done pulses
        check_val("request count", seen_reqs, total_exp);
        check_val("layer_done_o count", done_cnt, layer_nreq_q.size());
        $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt + proto_cnt);
        if (mism_cnt == 0 && fail_cnt == 0 && proto_cnt == 0 && total_exp > 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* dma_ctrl_top.f */
source/cnn_layer_pkg.sv
source/dma_cmd_pkg.sv
source/layer_cfg_regs.sv
source/tile_scheduler.sv
source/dma_addr_gen.sv
source/dma_ctrl_top.sv
dv/dma_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the DMA controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --top-module dma_ctrl_tb -f dma_ctrl_top.f -o dma_ctrl_sim

# a non-zero exit of the simulation stops the script here
./obj_dir/dma_ctrl_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished, see sim.log"

/* dv/dma_ctrl_trace.txt */
# per layer: cfg <reg> <data> ... go, then req <kind> <addr> <len> ... end, all numbers hex
# kind 0 filter, 1 ifmap, 2 bias, 3 opsum
# PW layer: in 4x4, in_d 8, out_k 4, tile_d 4, tile_k 2, tile_n 8, num_n 2
cfg 0 0 cfg 1 4 cfg 2 4 cfg 3 8 cfg 4 4 cfg 5 4 cfg 6 2 cfg 7 8 cfg 8 2
cfg 9 1000 cfg a 2000 cfg b 3000 cfg c 4000 go
req 2 3000 4 req 0 2000 8 req 1 1000 8 req 1 1010 8 req 1 1020 8 req 1 1030 8 req 0 2010 8
req 1 1040 8 req 1 1050 8 req 1 1060 8 req 1 1070 8 req 3 4000 10 req 3 4020 10
req 2 3004 4 req 0 2008 8 req 1 1000 8 req 1 1010 8 req 1 1020 8 req 1 1030 8 req 0 2018 8
req 1 1040 8 req 1 1050 8 req 1 1060 8 req 1 1070 8 req 3 4040 10 req 3 4060 10
req 2 3000 4 req 0 2000 8 req 1 1008 8 req 1 1018 8 req 1 1028 8 req 1 1038 8 req 0 2010 8
req 1 1048 8 req 1 1058 8 req 1 1068 8 req 1 1078 8 req 3 4010 10 req 3 4030 10
req 2 3004 4 req 0 2008 8 req 1 1008 8 req 1 1018 8 req 1 1028 8 req 1 1038 8 req 0 2018 8
req 1 1048 8 req 1 1058 8 req 1 1068 8 req 1 1078 8 req 3 4050 10 req 3 4070 10
end
# DW layer: in 4x4, out_k 4, tile_k 2, tile_n 1 row, num_n 2
cfg 0 1 cfg 1 4 cfg 2 4 cfg 3 4 cfg 4 4 cfg 5 2 cfg 6 2 cfg 7 1 cfg 8 2
cfg 9 5000 cfg a 6000 cfg b 7000 cfg c 8000 go
req 2 7000 4 req 0 6000 12 req 1 5000 4 req 1 5010 4 req 3 8000 8 req 3 8020 8
req 2 7004 4 req 0 6012 12 req 1 5020 4 req 1 5030 4 req 3 8040 8 req 3 8060 8
req 2 7000 4 req 0 6000 12 req 1 5004 4 req 1 5014 4 req 3 8008 8 req 3 8028 8
req 2 7004 4 req 0 6012 12 req 1 5024 4 req 1 5034 4 req 3 8048 8 req 3 8068 8
end
